// File: build.f
pkt_pkg.sv
byte_fifo.sv
inpkt_ctrl.sv
inpkt_fields.sv
outpkt_report.sv
word_to_axis8.sv
status_regs.sv
pkt_comm_top.sv
tb_pkt_comm.sv

// File: tb_pkt_comm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the packet front end
// Sends packets, collects the byte reports and checks status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_pkt_comm;

  // Six tests plus reset, each well under 500 cycles
  localparam int MAX_CYCLES  = 8 * 500;
  localparam int REPORT_WAIT = 300;

  // Error bit order is version, type, length, checksum
  localparam pkt_pkg::pkt_err_t NO_ERR    = pkt_pkg::pkt_err_t'(4'b0000);
  localparam pkt_pkg::pkt_err_t ERR_CSUM  = pkt_pkg::pkt_err_t'(4'b0001);
  localparam pkt_pkg::pkt_err_t ERR_VTC   = pkt_pkg::pkt_err_t'(4'b1101);
  localparam pkt_pkg::pkt_err_t ERR_ALL   = pkt_pkg::pkt_err_t'(4'b1111);

  logic                   CLK;
  logic                   RSTN;
  pkt_pkg::byte_t         s_tdata;
  logic                   s_tvalid;
  logic                   s_tlast;
  logic                   s_tready;
  pkt_pkg::byte_t         m_tdata;
  logic                   m_tvalid;
  logic                   m_tlast;
  logic                   m_tready;
  pkt_pkg::pkt_err_t      status;
  logic                   error_o;
  logic                   idle;

  integer                 seed = 32'h37e2ee28;
  int                     err_count;
  int                     tests_run;
  int                     tests_failed;
  int                     cycle_count;
  int                     send_len;
  pkt_pkg::byte_t         pkt_bytes [$];
  pkt_pkg::word16_t       exp_words [4];
  pkt_pkg::word16_t       got_words [4];

  pkt_comm_top pkt_comm_top_inst (
    .CLK, .RSTN, .s_tdata, .s_tvalid, .s_tlast, .s_tready,
    .m_tdata, .m_tvalid, .m_tlast, .m_tready,
    .pkt_comm_status(status), .error_o, .idle
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_word(input string name, input pkt_pkg::word16_t exp,
                            input pkt_pkg::word16_t act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_err(input string name, input pkt_pkg::pkt_err_t exp,
                           input pkt_pkg::pkt_err_t act);
    if (exp !== act) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      err_count++;
    end
  endtask

  // Header, random payload and XOR byte, plus the expected report words
  task automatic build_packet(input pkt_pkg::byte_t ver, input pkt_pkg::byte_t typ,
                              input pkt_pkg::word16_t id, input pkt_pkg::word16_t len,
                              input bit bad_csum, input int cut);
    pkt_pkg::byte_t   b;
    pkt_pkg::byte_t   csum;
    pkt_pkg::word16_t sum;
    int               i;
    pkt_bytes.delete();
    pkt_bytes.push_back(ver);
    pkt_bytes.push_back(typ);
    pkt_bytes.push_back(id[7:0]);
    pkt_bytes.push_back(id[15:8]);
    pkt_bytes.push_back(len[7:0]);
    pkt_bytes.push_back(len[15:8]);
    sum = '0;
    for (i = 0; i < int'(len); i++) begin
      b = $random(seed);
      pkt_bytes.push_back(b);
      sum = sum + {8'h00, b};
    end
    csum = '0;
    for (i = 0; i < pkt_bytes.size(); i++)
      csum = csum ^ pkt_bytes[i];
    if (bad_csum)
      csum = csum ^ 8'h5a;
    pkt_bytes.push_back(csum);
    // A cut packet raises last early
    send_len = pkt_bytes.size() - cut;
    exp_words[0] = {ver, typ};
    exp_words[1] = id;
    exp_words[2] = len;
    exp_words[3] = sum;
  endtask

  task automatic drive_packet();
    int i;
    for (i = 0; i < send_len; i++) begin
      s_tdata  <= pkt_bytes[i];
      s_tvalid <= 1'b1;
      s_tlast  <= (i == send_len - 1);
      do
        @(posedge CLK);
      while (!s_tready);
    end
    s_tvalid <= 1'b0;
    s_tlast  <= 1'b0;
  endtask

  task automatic collect_report(input string name, input bit stall);
    pkt_pkg::byte_t got_bytes [8];
    integer         rnd;
    int             n;
    int             waited;
    n      = 0;
    waited = 0;
    while (n < 8 && waited < REPORT_WAIT) begin
      @(posedge CLK);
      if (m_tvalid && m_tready) begin
        got_bytes[n] = m_tdata;
        check_bit({name, " m_tlast"}, (n == 7), m_tlast);
        n++;
      end
      waited++;
      rnd = $random(seed);
      m_tready <= stall ? rnd[0] : 1'b1;
    end
    m_tready <= 1'b1;
    if (n < 8) begin
      $display("%s: only %0d of 8 report bytes arrived in time", name, n);
      err_count++;
    end
    // Low byte first on the wire
    for (n = 0; n < 4; n++)
      got_words[n] = {got_bytes[2*n+1], got_bytes[2*n]};
  endtask

  task automatic compare_report(input string name);
    int k;
    for (k = 0; k < 4; k++)
      check_word($sformatf("%s word %0d", name, k), exp_words[k], got_words[k]);
  endtask

  task automatic expect_quiet(input string name, input int n_cycles);
    int seen;
    int k;
    seen = 0;
    for (k = 0; k < n_cycles; k++) begin
      @(posedge CLK);
      if (m_tvalid)
        seen++;
    end
    if (seen != 0) begin
      $display("%s: the report stream carried %0d unexpected byte cycles", name, seen);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name, input int e0);
    tests_run++;
    if (err_count == e0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, err_count - e0);
      tests_failed++;
    end
  endtask

  task automatic test_good_packet();
    int e0;
    e0 = err_count;
    build_packet(pkt_pkg::PKT_VERSION, 8'd3, 16'h1234, 16'd10, 1'b0, 0);
    fork
      drive_packet();
      collect_report("good_packet", 1'b0);
    join
    compare_report("good_packet");
    expect_quiet("good_packet", 10);
    check_err("good_packet status", NO_ERR, status);
    check_bit("good_packet error_o", 1'b0, error_o);
    finish_test("good_packet", e0);
  endtask

  task automatic test_stalled_output();
    int e0;
    e0 = err_count;
    build_packet(pkt_pkg::PKT_VERSION, 8'd1, 16'hbeef, 16'd10, 1'b0, 0);
    fork
      drive_packet();
      collect_report("stalled_output", 1'b1);
    join
    compare_report("stalled_output");
    expect_quiet("stalled_output", 10);
    finish_test("stalled_output", e0);
  endtask

  task automatic test_bad_checksum();
    int e0;
    e0 = err_count;
    build_packet(pkt_pkg::PKT_VERSION, 8'd2, 16'h0042, 16'd10, 1'b1, 0);
    drive_packet();
    expect_quiet("bad_checksum", 100);
    check_err("bad_checksum status", ERR_CSUM, status);
    check_bit("bad_checksum error_o", 1'b1, error_o);
    finish_test("bad_checksum", e0);
  endtask

  task automatic test_bad_version_type();
    int e0;
    e0 = err_count;
    build_packet(8'd3, 8'd2, 16'h0101, 16'd4, 1'b0, 0);
    drive_packet();
    expect_quiet("bad_version_type", 50);
    build_packet(pkt_pkg::PKT_VERSION, 8'd7, 16'h0202, 16'd4, 1'b0, 0);
    drive_packet();
    expect_quiet("bad_version_type", 50);
    check_err("bad_version_type status", ERR_VTC, status);
    finish_test("bad_version_type", e0);
  endtask

  task automatic test_early_last();
    int e0;
    e0 = err_count;
    build_packet(pkt_pkg::PKT_VERSION, 8'd1, 16'h0303, 16'd10, 1'b0, 2);
    drive_packet();
    expect_quiet("early_last", 50);
    check_err("early_last status", ERR_ALL, status);
    // The next packet must start cleanly
    build_packet(pkt_pkg::PKT_VERSION, 8'd4, 16'h5aa5, 16'd10, 1'b0, 0);
    fork
      drive_packet();
      collect_report("early_last", 1'b0);
    join
    compare_report("early_last");
    expect_quiet("early_last", 10);
    finish_test("early_last", e0);
  endtask

  task automatic test_idle_after_traffic();
    int e0;
    int n;
    e0 = err_count;
    n  = 0;
    // Rejected packet, so only the input side is busy
    build_packet(8'd5, 8'd2, 16'h0404, 16'd4, 1'b0, 0);
    drive_packet();
    check_bit("idle_after_traffic idle during traffic", 1'b0, idle);
    while (!idle && n < 20) begin
      @(posedge CLK);
      n++;
    end
    check_bit("idle_after_traffic idle", 1'b1, idle);
    check_bit("idle_after_traffic error_o", 1'b1, error_o);
    finish_test("idle_after_traffic", e0);
  endtask

  initial begin
    RSTN         = 1'b0;
    s_tdata      = '0;
    s_tvalid     = 1'b0;
    s_tlast      = 1'b0;
    m_tready     = 1'b0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge CLK);
    RSTN     <= 1'b1;
    m_tready <= 1'b1;
    repeat (2) @(posedge CLK);

    test_good_packet();
    test_stalled_output();
    test_bad_checksum();
    test_bad_version_type();
    test_early_last();
    test_idle_after_traffic();

    $display("Tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: pkt_comm_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet front end top, 8-bit stream in and report stream out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pkt_comm_top (
  input  wire                  CLK,
  input  wire                  RSTN,
  input  wire pkt_pkg::byte_t  s_tdata,
  input  wire                  s_tvalid,
  input  wire                  s_tlast,
  output logic                 s_tready,
  output pkt_pkg::byte_t       m_tdata,
  output logic                 m_tvalid,
  output logic                 m_tlast,
  input  wire                  m_tready,
  output pkt_pkg::pkt_err_t    pkt_comm_status,
  output logic                 error_o,
  output logic                 idle
);

  pkt_pkg::fifo_entry_t entry;
  pkt_pkg::in_byte_t    in_byte;
  pkt_pkg::pkt_err_t    errs;
  pkt_pkg::pkt_hdr_t    hdr;
  pkt_pkg::word16_t     pay_sum;
  pkt_pkg::word16_t     word;
  logic                 empty;
  logic                 pop;
  logic                 report_start;
  logic                 report_busy;
  logic                 err_strobe;
  logic                 ctrl_idle;
  logic                 word_valid;
  logic                 word_last;
  logic                 word_take;

  byte_fifo byte_fifo_inst (
    .CLK, .RSTN, .s_tdata, .s_tvalid, .s_tlast, .s_tready,
    .entry, .empty, .pop
  );

  inpkt_ctrl inpkt_ctrl_inst (
    .CLK, .RSTN, .entry, .empty, .pop, .in_byte, .errs,
    .report_start, .report_busy, .err_strobe, .ctrl_idle
  );

  inpkt_fields inpkt_fields_inst (
    .CLK, .RSTN, .in_byte, .hdr, .pay_sum, .errs
  );

  outpkt_report outpkt_report_inst (
    .CLK, .RSTN, .report_start, .hdr, .pay_sum,
    .word, .word_valid, .word_last, .word_take, .report_busy
  );

  word_to_axis8 word_to_axis8_inst (
    .CLK, .RSTN, .word, .word_valid, .word_last, .word_take,
    .m_tdata, .m_tvalid, .m_tlast, .m_tready
  );

  status_regs status_regs_inst (
    .CLK, .RSTN, .errs, .err_strobe, .ctrl_idle, .report_busy, .s_tvalid,
    .pkt_comm_status, .error_o, .idle
  );

endmodule

`default_nettype wire

// File: status_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sticky packet error status, error flag and delayed idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module status_regs (
  input  wire                    CLK,
  input  wire                    RSTN,
  input  wire pkt_pkg::pkt_err_t errs,
  input  wire                    err_strobe,
  input  wire                    ctrl_idle,
  input  wire                    report_busy,
  input  wire                    s_tvalid,
  output pkt_pkg::pkt_err_t      pkt_comm_status,
  output logic                   error_o,
  output logic                   idle
);

  pkt_pkg::pkt_err_t               sticky;
  logic [pkt_pkg::IDLE_DELAY-1:0]  idle_sr;
  logic                            idle_in;

  assign pkt_comm_status = sticky;
  assign error_o         = |sticky;

  // Nothing buffered, nothing reporting, nothing arriving
  assign idle_in = ctrl_idle && !report_busy && !s_tvalid;
  assign idle    = idle_sr[pkt_pkg::IDLE_DELAY-1];

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      sticky  <= '0;
      idle_sr <= '1;
    end else begin
      if (err_strobe)
        sticky <= sticky | errs;
      idle_sr <= {idle_sr[pkt_pkg::IDLE_DELAY-2:0], idle_in};
    end
  end

endmodule

`default_nettype wire

// File: word_to_axis8.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-to-8 serializer onto the output stream, low byte first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module word_to_axis8 (
  input  wire                   CLK,
  input  wire                   RSTN,
  input  wire pkt_pkg::word16_t word,
  input  wire                   word_valid,
  input  wire                   word_last,
  output logic                  word_take,
  output pkt_pkg::byte_t        m_tdata,
  output logic                  m_tvalid,
  output logic                  m_tlast,
  input  wire                   m_tready
);

  pkt_pkg::word16_t shreg;
  logic             last_q;
  logic             pending;
  logic             phase;   // 0 low byte, 1 high byte

  // New word only once both bytes have left
  assign word_take = word_valid && !pending;

  assign m_tdata  = phase ? shreg[15:8] : shreg[7:0];
  assign m_tvalid = pending;
  assign m_tlast  = pending && phase && last_q;

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      pending <= 1'b0;
      phase   <= 1'b0;
      last_q  <= 1'b0;
    end else if (word_take) begin
      pending <= 1'b1;
      phase   <= 1'b0;
      last_q  <= word_last;
    end else if (pending && m_tready) begin
      if (phase)
        pending <= 1'b0;
      phase <= ~phase;
    end
  end

  always_ff @(posedge CLK) begin
    if (word_take)
      shreg <= word;
  end

endmodule

`default_nettype wire

// File: outpkt_report.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Report word holder, hands out four 16-bit words in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module outpkt_report (
  input  wire                    CLK,
  input  wire                    RSTN,
  input  wire                    report_start,
  input  wire pkt_pkg::pkt_hdr_t hdr,
  input  wire pkt_pkg::word16_t  pay_sum,
  output pkt_pkg::word16_t       word,
  output logic                   word_valid,
  output logic                   word_last,
  input  wire                    word_take,
  output logic                   report_busy
);

  pkt_pkg::word16_t                words [pkt_pkg::REPORT_WORDS];
  logic [pkt_pkg::REPORT_IW-1:0]   idx;
  logic                            busy;

  assign word        = words[idx];
  assign word_valid  = busy;
  assign word_last   = busy && (idx == pkt_pkg::REPORT_IW'(pkt_pkg::REPORT_WORDS - 1));
  assign report_busy = busy;

  // Version and type share the first word
  always_ff @(posedge CLK) begin
    if (report_start) begin
      words[0] <= {hdr.version, hdr.pkt_type};
      words[1] <= hdr.id;
      words[2] <= hdr.length;
      words[3] <= pay_sum;
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (report_start) begin
      busy <= 1'b1;
      idx  <= '0;
    end else if (busy && word_take) begin
      busy <= !word_last;
      idx  <= word_last ? '0 : idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: inpkt_fields.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header capture and packet checks
// XOR checksum, payload sum and body length tracking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module inpkt_fields (
  input  wire                    CLK,
  input  wire                    RSTN,
  input  wire pkt_pkg::in_byte_t in_byte,
  output pkt_pkg::pkt_hdr_t      hdr,
  output pkt_pkg::word16_t       pay_sum,
  output pkt_pkg::pkt_err_t      errs
);

  pkt_pkg::byte_t    xor_acc;
  pkt_pkg::byte_t    xor_next;
  pkt_pkg::word16_t  body_cnt;
  pkt_pkg::pkt_err_t chk;
  logic              first;
  logic              body_byte;

  assign first     = in_byte.in_hdr && (in_byte.idx == '0);
  assign body_byte = !in_byte.in_hdr && !in_byte.is_end;
  assign xor_next  = first ? in_byte.data : (xor_acc ^ in_byte.data);

  // Checks applied when the end byte arrives
  always_comb begin
    chk.version  = (hdr.version != pkt_pkg::PKT_VERSION);
    chk.pkt_type = (hdr.pkt_type < pkt_pkg::PKT_TYPE_MIN) ||
                   (hdr.pkt_type > pkt_pkg::PKT_TYPE_MAX);
    chk.length   = in_byte.in_hdr || (body_cnt != hdr.length);
    chk.checksum = (xor_next != '0);
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      xor_acc  <= '0;
      body_cnt <= '0;
      errs     <= '0;
    end else if (in_byte.valid) begin
      xor_acc <= xor_next;
      if (first) begin
        body_cnt <= '0;
        errs     <= '0;
      end else if (body_byte) begin
        body_cnt <= body_cnt + 1'b1;
      end
      if (in_byte.is_end)
        errs <= chk;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_byte.valid) begin
      if (first)
        pay_sum <= '0;
      else if (body_byte)
        pay_sum <= pay_sum + {8'h00, in_byte.data};
      if (in_byte.in_hdr && !in_byte.is_end) begin
        case (in_byte.idx)
          3'd0:    hdr.version      <= in_byte.data;
          3'd1:    hdr.pkt_type     <= in_byte.data;
          3'd2:    hdr.id[7:0]      <= in_byte.data;
          3'd3:    hdr.id[15:8]     <= in_byte.data;
          3'd4:    hdr.length[7:0]  <= in_byte.data;
          3'd5:    hdr.length[15:8] <= in_byte.data;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: inpkt_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inbound packet control FSM
// Pops bytes, tracks header/body phase and starts reports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module inpkt_ctrl (
  input  wire                       CLK,
  input  wire                       RSTN,
  input  wire pkt_pkg::fifo_entry_t entry,
  input  wire                       empty,
  output logic                      pop,
  output pkt_pkg::in_byte_t         in_byte,
  input  wire pkt_pkg::pkt_err_t    errs,
  output logic                      report_start,
  input  wire                       report_busy,
  output logic                      err_strobe,
  output logic                      ctrl_idle
);

  pkt_pkg::ctrl_state_t state;
  pkt_pkg::hdr_idx_t    idx;
  logic                 any_err;
  logic                 hdr_done;

  assign any_err  = |errs;
  assign hdr_done = (idx == pkt_pkg::hdr_idx_t'(pkt_pkg::HDR_LEN - 1));

  // Pull bytes only while walking a packet
  assign pop = ~empty && (state == pkt_pkg::HEADER || state == pkt_pkg::BODY);

  always_comb begin
    in_byte.data   = entry.data;
    in_byte.valid  = pop;
    in_byte.in_hdr = (state == pkt_pkg::HEADER);
    in_byte.idx    = idx;
    in_byte.is_end = entry.last;
  end

  // Errors are settled by the time DECIDE is reached
  assign err_strobe   = (state == pkt_pkg::DECIDE);
  assign report_start = (state == pkt_pkg::DECIDE) && !any_err;
  assign ctrl_idle    = (state == pkt_pkg::HEADER) && (idx == '0) && empty;

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state <= pkt_pkg::HEADER;
      idx   <= '0;
    end else begin
      case (state)
        pkt_pkg::HEADER: begin
          if (pop) begin
            if (entry.last) begin
              // Short packet, fields flag the length
              state <= pkt_pkg::DECIDE;
              idx   <= '0;
            end else if (hdr_done) begin
              state <= pkt_pkg::BODY;
              idx   <= '0;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        pkt_pkg::BODY: begin
          if (pop && entry.last)
            state <= pkt_pkg::DECIDE;
        end
        pkt_pkg::DECIDE: begin
          state <= any_err ? pkt_pkg::HEADER : pkt_pkg::REPORT;
        end
        pkt_pkg::REPORT: begin
          // Input stays parked until the report words are handed out
          if (!report_busy)
            state <= pkt_pkg::HEADER;
        end
        default: begin
          state <= pkt_pkg::HEADER;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: byte_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inbound byte FIFO, stores each byte with its last flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module byte_fifo (
  input  wire                  CLK,
  input  wire                  RSTN,
  input  wire pkt_pkg::byte_t  s_tdata,
  input  wire                  s_tvalid,
  input  wire                  s_tlast,
  output logic                 s_tready,
  output pkt_pkg::fifo_entry_t entry,
  output logic                 empty,
  input  wire                  pop
);

  pkt_pkg::fifo_entry_t      mem [pkt_pkg::FIFO_DEPTH];
  logic [pkt_pkg::FIFO_AW:0] wr_ptr;
  logic [pkt_pkg::FIFO_AW:0] rd_ptr;
  logic                      full;
  logic                      ready_en;
  logic                      push;

  // Same slot but different wrap bit means full
  assign full     = (wr_ptr[pkt_pkg::FIFO_AW] != rd_ptr[pkt_pkg::FIFO_AW]) &&
                    (wr_ptr[pkt_pkg::FIFO_AW-1:0] == rd_ptr[pkt_pkg::FIFO_AW-1:0]);
  assign empty    = (wr_ptr == rd_ptr);
  assign s_tready = ready_en & ~full;
  assign push     = s_tvalid & s_tready;
  assign entry    = mem[rd_ptr[pkt_pkg::FIFO_AW-1:0]];

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      ready_en <= 1'b0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
    end else begin
      ready_en <= 1'b1;   // one quiet cycle out of reset
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (push)
      mem[wr_ptr[pkt_pkg::FIFO_AW-1:0]] <= '{data: s_tdata, last: s_tlast};
  end

endmodule

`default_nettype wire

// File: pkt_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet front end shared definitions
// Widths, format constants, state enum and bundled signals
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pkt_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word16_t;
  typedef logic [7:0]  pkt_type_t;
  typedef logic [2:0]  hdr_idx_t;

  // Packet format
  localparam byte_t     PKT_VERSION  = 8'd2;
  localparam pkt_type_t PKT_TYPE_MIN = 8'd1;
  localparam pkt_type_t PKT_TYPE_MAX = 8'd4;
  localparam int        HDR_LEN      = 6;

  // Buffering and timing
  localparam int FIFO_DEPTH   = 64;
  localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
  localparam int IDLE_DELAY   = 6;
  localparam int REPORT_WORDS = 4;
  localparam int REPORT_IW    = $clog2(REPORT_WORDS);

  typedef struct packed {
    byte_t data;
    logic  last;
  } fifo_entry_t;

  // One popped byte with its position in the packet
  typedef struct packed {
    byte_t    data;
    logic     valid;
    logic     in_hdr;
    hdr_idx_t idx;
    logic     is_end;
  } in_byte_t;

  typedef struct packed {
    logic version;
    logic pkt_type;
    logic length;
    logic checksum;
  } pkt_err_t;

  typedef struct packed {
    byte_t     version;
    pkt_type_t pkt_type;
    word16_t   id;
    word16_t   length;
  } pkt_hdr_t;

  typedef enum logic [1:0] {HEADER, BODY, DECIDE, REPORT} ctrl_state_t;

endpackage

`default_nettype wire
